/* rtl/dengine_pkg.sv */
package dengine_pkg;

   // host and datapath sizes
   localparam int DATA_W      = 32;
   localparam int DATAPATH_W  = 16;
   localparam int N_MEM       = 2;
   localparam int N_ALU       = 2;
   localparam int MEM_ADDR_W  = 5;
   localparam int HOST_ADDR_W = 7;
   localparam int SEL_W       = 3;
   localparam int CONF_WORDS  = 11;
   localparam int LEN_W       = 6;

   typedef logic signed [DATAPATH_W-1:0] data_t;
   typedef logic [HOST_ADDR_W-1:0] host_addr_t;

   // upper two host address bits
   typedef enum logic [1:0] {
      REG_MEM0,
      REG_MEM1,
      REG_CTRL,
      REG_CONF
   } region_e;

   typedef enum logic [SEL_W-1:0] {
      SRC_NONE = 3'd0,
      SRC_MEM0 = 3'd1,
      SRC_MEM1 = 3'd2,
      SRC_ALU0 = 3'd3,
      SRC_ALU1 = 3'd4
   } src_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_MAX,
      ALU_MIN
   } alu_op_e;

   typedef struct packed {
      data_t mem0;
      data_t mem1;
      data_t alu0;
      data_t alu1;
   } data_bus_t;

   typedef struct packed {
      logic [MEM_ADDR_W-1:0] a_start;
      logic [MEM_ADDR_W-1:0] b_start;
      src_e                  b_sel;
      logic [3:0]            b_delay;
   } mem_conf_t;

   typedef struct packed {
      src_e    sel_a;
      src_e    sel_b;
      alu_op_e op;
   } alu_conf_t;

   typedef struct packed {
      mem_conf_t [N_MEM-1:0] mem;
      alu_conf_t [N_ALU-1:0] alu;
      logic [LEN_W-1:0]      len;
   } engine_conf_t;

   typedef struct packed {
      logic            valid;
      logic            we;
      host_addr_t      addr;
      logic [DATA_W-1:0] wr_data;
   } host_req_t;

   // source select shared by all units, unused codes give zero
   function automatic data_t bus_pick(data_bus_t bus, src_e sel);
      case (sel)
         SRC_MEM0: return bus.mem0;
         SRC_MEM1: return bus.mem1;
         SRC_ALU0: return bus.alu0;
         SRC_ALU1: return bus.alu1;
         default:  return '0;
      endcase
   endfunction

endpackage

/* rtl/dengine_conf.sv */
`timescale 1ns/1ps

module dengine_conf (
   input  logic                      rst,
   input  logic                      clk,
   input  dengine_pkg::host_req_t    host_req,
   input  logic                      run,
   output dengine_pkg::engine_conf_t shadow
);

   dengine_pkg::engine_conf_t staging;
   logic [dengine_pkg::MEM_ADDR_W-1:0] offset;
   logic [dengine_pkg::DATA_W-1:0] wd;
   logic conf_we;

   assign offset  = host_req.addr[dengine_pkg::MEM_ADDR_W-1:0];
   assign wd      = host_req.wr_data;
   assign conf_we = host_req.valid && host_req.we &&
                    host_req.addr[dengine_pkg::HOST_ADDR_W-1:dengine_pkg::MEM_ADDR_W] ==
                    dengine_pkg::REG_CONF;

   // staging words, four per memory, then one per alu, then len
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         staging <= '0;
      end else if (conf_we) begin
         if (int'(offset) < 4 * dengine_pkg::N_MEM) begin
            case (offset[1:0])
               2'd0: staging.mem[offset[2]].a_start <= wd[dengine_pkg::MEM_ADDR_W-1:0];
               2'd1: staging.mem[offset[2]].b_start <= wd[dengine_pkg::MEM_ADDR_W-1:0];
               2'd2: staging.mem[offset[2]].b_sel   <= dengine_pkg::src_e'(wd[2:0]);
               default: staging.mem[offset[2]].b_delay <= wd[3:0];
            endcase
         end else if (int'(offset) < dengine_pkg::CONF_WORDS - 1) begin
            staging.alu[offset[0]].sel_a <= dengine_pkg::src_e'(wd[2:0]);
            staging.alu[offset[0]].sel_b <= dengine_pkg::src_e'(wd[5:3]);
            staging.alu[offset[0]].op    <= dengine_pkg::alu_op_e'(wd[8:6]);
         end else if (int'(offset) == dengine_pkg::CONF_WORDS - 1) begin
            staging.len <= wd[dengine_pkg::LEN_W-1:0];
         end
      end
   end

   // kernel sees a frozen copy for the whole run
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         shadow <= '0;
      end else if (run) begin
         shadow <= staging;
      end
   end

endmodule

/* rtl/dengine_mem.sv */
`timescale 1ns/1ps

module dengine_mem (
   input  logic                               rst,
   input  logic                               clk,
   input  logic                               run_start,
   input  logic [dengine_pkg::LEN_W-1:0]      len,
   input  dengine_pkg::mem_conf_t             conf,
   input  logic                               host_valid,
   input  logic                               host_we,
   input  logic [dengine_pkg::MEM_ADDR_W-1:0] host_addr,
   input  dengine_pkg::data_t                 host_wdata,
   input  dengine_pkg::data_bus_t             data_bus,
   output dengine_pkg::data_t                 out,
   output logic                               done
);

   dengine_pkg::data_t ram [2**dengine_pkg::MEM_ADDR_W];

   logic host_rd;
   logic host_wr;

   // port A read stream
   logic                               a_busy;
   logic [dengine_pkg::LEN_W-1:0]      a_cnt;
   logic [dengine_pkg::LEN_W-1:0]      a_k;
   logic [dengine_pkg::LEN_W-1:0]      a_next;
   logic                               a_issue;
   logic [dengine_pkg::MEM_ADDR_W-1:0] a_addr;

   // port B delay then write stream
   logic                               b_wait;
   logic [3:0]                         b_dly;
   logic [3:0]                         b_dly_k;
   logic                               b_waiting;
   logic                               b_first;
   logic                               b_busy;
   logic [dengine_pkg::LEN_W-1:0]      b_cnt;
   logic [dengine_pkg::LEN_W-1:0]      b_k;
   logic [dengine_pkg::LEN_W-1:0]      b_next;
   logic                               b_issue;
   logic                               b_we;
   logic [dengine_pkg::MEM_ADDR_W-1:0] b_addr;
   dengine_pkg::data_t                 b_data;

   assign host_rd = host_valid & ~host_we;
   assign host_wr = host_valid & host_we;

   // first read goes out in the run_start cycle itself
   assign a_k     = run_start ? '0 : a_cnt;
   assign a_next  = a_k + 1'b1;
   assign a_issue = run_start ? (len != '0) : a_busy;
   assign a_addr  = host_rd ? host_addr : conf.a_start + a_k[dengine_pkg::MEM_ADDR_W-1:0];

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         a_busy <= 1'b0;
         a_cnt  <= '0;
      end else begin
         a_busy <= a_issue && (a_next != len);
         if (a_issue) begin
            a_cnt <= a_next;
         end
      end
   end

   // b_dly counts cycles since run_start
   assign b_dly_k   = run_start ? 4'd0 : b_dly;
   assign b_waiting = run_start ? (len != '0) : b_wait;
   assign b_first   = b_waiting && (b_dly_k == conf.b_delay);
   assign b_k       = b_first ? '0 : b_cnt;
   assign b_next    = b_k + 1'b1;
   assign b_issue   = b_first | (b_busy & ~run_start);
   assign b_we      = b_issue && (conf.b_sel != dengine_pkg::SRC_NONE);

   assign b_addr = host_wr ? host_addr : conf.b_start + b_k[dengine_pkg::MEM_ADDR_W-1:0];
   assign b_data = host_wr ? host_wdata : dengine_pkg::bus_pick(data_bus, conf.b_sel);

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         b_wait <= 1'b0;
         b_dly  <= '0;
         b_busy <= 1'b0;
         b_cnt  <= '0;
      end else begin
         b_wait <= b_waiting & ~b_first;
         b_dly  <= b_dly_k + 1'b1;
         b_busy <= b_issue && (b_next != len);
         if (b_issue) begin
            b_cnt <= b_next;
         end
      end
   end

   // port A, output register doubles as the bus word
   always_ff @(posedge rst) begin
      if (host_rd | a_issue) begin
         out <= ram[a_addr];
      end
   end

   // port B
   always_ff @(posedge rst) begin
      if (host_wr | b_we) begin
         ram[b_addr] <= b_data;
      end
   end

   // run_start counts as busy so a poll right after the run sees 0
   assign done = ~(run_start | a_busy | b_wait | b_busy);

endmodule

/* rtl/dengine_alu.sv */
`timescale 1ns/1ps

module dengine_alu (
   input  logic                   rst,
   input  logic                   clk,
   input  logic                   run_start,
   input  dengine_pkg::alu_conf_t conf,
   input  dengine_pkg::data_bus_t data_bus,
   output dengine_pkg::data_t     out
);

   dengine_pkg::data_t a;
   dengine_pkg::data_t b;
   dengine_pkg::data_t result;

   assign a = dengine_pkg::bus_pick(data_bus, conf.sel_a);
   assign b = dengine_pkg::bus_pick(data_bus, conf.sel_b);

   // data_t is signed so max and min compare signed
   always_comb begin
      case (conf.op)
         dengine_pkg::ALU_ADD: result = a + b;
         dengine_pkg::ALU_SUB: result = a - b;
         dengine_pkg::ALU_AND: result = a & b;
         dengine_pkg::ALU_OR:  result = a | b;
         dengine_pkg::ALU_XOR: result = a ^ b;
         dengine_pkg::ALU_MAX: result = (a > b) ? a : b;
         dengine_pkg::ALU_MIN: result = (a < b) ? a : b;
         default:              result = '0;
      endcase
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         out <= '0;
      end else if (run_start) begin
         out <= '0;
      end else begin
         out <= result;
      end
   end

endmodule

/* rtl/dengine_eng.sv */
`timescale 1ns/1ps

module dengine_eng (
   input  logic                            rst,
   input  logic                            clk,
   input  dengine_pkg::host_req_t          host_req,
   input  dengine_pkg::engine_conf_t       conf,
   output logic                            run,
   output logic [dengine_pkg::DATA_W-1:0]  rd_data
);

   dengine_pkg::region_e                  region;
   logic                                  ctrl_valid;
   logic [dengine_pkg::N_MEM-1:0]         mem_valid;
   logic [dengine_pkg::N_MEM-1:0]         mem_done;
   logic                                  done;
   logic                                  run_start;
   logic                                  rd_pend;
   logic                                  rd_idx;
   dengine_pkg::data_t                    rd_word;
   dengine_pkg::data_t [dengine_pkg::N_MEM-1:0] mem_out;
   dengine_pkg::data_t [dengine_pkg::N_ALU-1:0] alu_out;
   dengine_pkg::data_bus_t                data_bus;

   assign region = dengine_pkg::region_e'(
      host_req.addr[dengine_pkg::HOST_ADDR_W-1:dengine_pkg::MEM_ADDR_W]);

   // region decode
   always_comb begin
      mem_valid  = '0;
      ctrl_valid = host_req.valid && (region == dengine_pkg::REG_CTRL);
      if (host_req.valid) begin
         case (region)
            dengine_pkg::REG_MEM0: mem_valid[0] = 1'b1;
            dengine_pkg::REG_MEM1: mem_valid[1] = 1'b1;
            default: ;
         endcase
      end
   end

   assign run = ctrl_valid & host_req.we & host_req.wr_data[0];

   // run_start and the one-cycle memory readback
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         run_start <= 1'b0;
         rd_pend   <= 1'b0;
         rd_idx    <= 1'b0;
      end else begin
         run_start <= run;
         rd_pend   <= (|mem_valid) & ~host_req.we;
         rd_idx    <= mem_valid[1];
      end
   end

   assign data_bus.mem0 = mem_out[0];
   assign data_bus.mem1 = mem_out[1];
   assign data_bus.alu0 = alu_out[0];
   assign data_bus.alu1 = alu_out[1];

   assign done    = &mem_done;
   assign rd_word = rd_idx ? data_bus.mem1 : data_bus.mem0;

   always_comb begin
      if (ctrl_valid && !host_req.we) begin
         rd_data = {{(dengine_pkg::DATA_W-1){1'b0}}, done};
      end else if (rd_pend) begin
         rd_data = {{(dengine_pkg::DATA_W-dengine_pkg::DATAPATH_W){rd_word[15]}}, rd_word};
      end else begin
         rd_data = '0;
      end
   end

   for (genvar i = 0; i < dengine_pkg::N_MEM; i++) begin : g_mem
      dengine_mem u_mem (
         .rst        (rst),
         .clk        (clk),
         .run_start  (run_start),
         .len        (conf.len),
         .conf       (conf.mem[i]),
         .host_valid (mem_valid[i]),
         .host_we    (host_req.we),
         .host_addr  (host_req.addr[dengine_pkg::MEM_ADDR_W-1:0]),
         .host_wdata (host_req.wr_data[dengine_pkg::DATAPATH_W-1:0]),
         .data_bus   (data_bus),
         .out        (mem_out[i]),
         .done       (mem_done[i])
      );
   end

   for (genvar i = 0; i < dengine_pkg::N_ALU; i++) begin : g_alu
      dengine_alu u_alu (
         .rst       (rst),
         .clk       (clk),
         .run_start (run_start),
         .conf      (conf.alu[i]),
         .data_bus  (data_bus),
         .out       (alu_out[i])
      );
   end

endmodule

/* rtl/dengine_top.sv */
`timescale 1ns/1ps

module dengine_top (
   input  logic                           rst,
   input  logic                           clk,
   input  dengine_pkg::host_req_t         host_req,
   output logic [dengine_pkg::DATA_W-1:0] rd_data
);

   logic                      run;
   dengine_pkg::engine_conf_t shadow;

   dengine_conf u_conf (
      .rst      (rst),
      .clk      (clk),
      .host_req (host_req),
      .run      (run),
      .shadow   (shadow)
   );

   dengine_eng u_eng (
      .rst      (rst),
      .clk      (clk),
      .host_req (host_req),
      .conf     (shadow),
      .run      (run),
      .rd_data  (rd_data)
   );

endmodule

/* bench/dengine_clkgen.sv */
`timescale 1ns/1ps

module dengine_clkgen (
   output logic rst,
   output logic clk
);

   // 40 ns clock on rst
   initial begin
      rst = 1'b0;
      forever #20 rst = ~rst;
   end

   // reset on clk, released on a falling edge after 4 cycles
   initial begin
      clk = 1'b1;
      repeat (4) @(posedge rst);
      @(negedge rst);
      clk = 1'b0;
   end

endmodule

/* bench/dengine_tb.sv */
`timescale 1ns/1ps

module dengine_tb;

   logic                              rst;
   logic                              clk;
   dengine_pkg::host_req_t            host_req;
   logic [dengine_pkg::DATA_W-1:0]    rd_data;
   logic [dengine_pkg::DATA_W-1:0]    word;
   logic                              done_bit;
   dengine_pkg::data_t                model_mem [2][32];
   dengine_pkg::engine_conf_t         cfg;
   dengine_pkg::engine_conf_t         old_cfg;

   dengine_clkgen u_clkgen (.rst(rst), .clk(clk));

   dengine_top DUT (.rst(rst), .clk(clk), .host_req(host_req), .rd_data(rd_data));

   task automatic abort_run(string why);
      $display("%s", why);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_word(string name, dengine_pkg::data_t got, dengine_pkg::data_t exp);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED at %0t ns: %s got %h expected %h",
                             $time, name, got, exp));
      end
   endtask

   task automatic check_rdata(string name, logic [dengine_pkg::DATA_W-1:0] got,
                              logic [dengine_pkg::DATA_W-1:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED at %0t ns: %s got %h expected %h",
                             $time, name, got, exp));
      end
   endtask

   task automatic check_status(logic got, logic exp);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED at %0t ns: done got %b expected %b",
                             $time, got, exp));
      end
   endtask

   function automatic dengine_pkg::host_addr_t mem_addr(int m, int offs);
      return {(m == 0) ? dengine_pkg::REG_MEM0 : dengine_pkg::REG_MEM1, 5'(offs)};
   endfunction

   function automatic dengine_pkg::host_addr_t conf_addr(int offs);
      return {dengine_pkg::REG_CONF, 5'(offs)};
   endfunction

   // memory readback lands in word one cycle after the request
   task automatic host_access(logic we, dengine_pkg::host_addr_t addr, logic [31:0] wdata);
      @(negedge rst);
      host_req.valid   = 1'b1;
      host_req.we      = we;
      host_req.addr    = addr;
      host_req.wr_data = wdata;
      @(negedge rst);
      word     = rd_data;
      host_req = '0;
   endtask

   // status is combinational and is sampled a quarter period after driving
   task automatic read_status();
      @(negedge rst);
      host_req.valid = 1'b1;
      host_req.we    = 1'b0;
      host_req.addr  = {dengine_pkg::REG_CTRL, 5'd0};
      #10;
      done_bit = rd_data[0];
      @(negedge rst);
      host_req = '0;
   endtask

   task automatic wait_done();
      int polls;
      polls    = 0;
      done_bit = 1'b0;
      while (!done_bit) begin
         if (polls == 100) begin
            abort_run("engine status stayed busy past 100 polls");
         end
         read_status();
         polls++;
      end
   endtask

   task automatic write_conf(dengine_pkg::engine_conf_t c);
      for (int m = 0; m < 2; m++) begin
         host_access(1'b1, conf_addr(4 * m), 32'(c.mem[m].a_start));
         host_access(1'b1, conf_addr(4 * m + 1), 32'(c.mem[m].b_start));
         host_access(1'b1, conf_addr(4 * m + 2), 32'(c.mem[m].b_sel));
         host_access(1'b1, conf_addr(4 * m + 3), 32'(c.mem[m].b_delay));
      end
      for (int i = 0; i < 2; i++) begin
         host_access(1'b1, conf_addr(8 + i),
                     {23'd0, c.alu[i].op, c.alu[i].sel_b, c.alu[i].sel_a});
      end
      host_access(1'b1, conf_addr(10), 32'(c.len));
   endtask

   task automatic start_run();
      host_access(1'b1, {dengine_pkg::REG_CTRL, 5'd0}, 32'h1);
   endtask

   function automatic dengine_pkg::data_t alu_model(dengine_pkg::alu_op_e op,
                                                    dengine_pkg::data_t a,
                                                    dengine_pkg::data_t b);
      int ia;
      int ib;
      ia = a;
      ib = b;
      case (op)
         dengine_pkg::ALU_ADD: return 16'(ia + ib);
         dengine_pkg::ALU_SUB: return 16'(ia - ib);
         dengine_pkg::ALU_AND: return a & b;
         dengine_pkg::ALU_OR:  return a | b;
         dengine_pkg::ALU_XOR: return a ^ b;
         dengine_pkg::ALU_MAX: return (ia >= ib) ? a : b;
         dengine_pkg::ALU_MIN: return (ia <= ib) ? a : b;
         default:              return '0;
      endcase
   endfunction

   function automatic dengine_pkg::data_t source_value(dengine_pkg::data_bus_t bus,
                                                       dengine_pkg::src_e sel);
      if (sel == dengine_pkg::SRC_MEM0) return bus.mem0;
      if (sel == dengine_pkg::SRC_MEM1) return bus.mem1;
      if (sel == dengine_pkg::SRC_ALU0) return bus.alu0;
      if (sel == dengine_pkg::SRC_ALU1) return bus.alu1;
      return '0;
   endfunction

   // bus[t] holds the bus value at cycle S+t
   task automatic run_model(dengine_pkg::engine_conf_t c);
      dengine_pkg::data_bus_t bus [80];
      int n;
      int j;
      n = c.len;
      if (n == 0) begin
         return;
      end
      for (int t = 1; t < 80; t++) begin
         // port A register keeps its last word once the stream ends
         j = (t - 1 < n) ? t - 1 : n - 1;
         bus[t].mem0 = model_mem[0][5'(c.mem[0].a_start + j)];
         bus[t].mem1 = model_mem[1][5'(c.mem[1].a_start + j)];
         // alu registers cleared by run_start
         if (t == 1) begin
            bus[t].alu0 = '0;
            bus[t].alu1 = '0;
         end else begin
            bus[t].alu0 = alu_model(c.alu[0].op, source_value(bus[t-1], c.alu[0].sel_a),
                                    source_value(bus[t-1], c.alu[0].sel_b));
            bus[t].alu1 = alu_model(c.alu[1].op, source_value(bus[t-1], c.alu[1].sel_a),
                                    source_value(bus[t-1], c.alu[1].sel_b));
         end
      end
      for (int m = 0; m < 2; m++) begin
         if (c.mem[m].b_sel != dengine_pkg::SRC_NONE) begin
            for (int k = 0; k < n; k++) begin
               model_mem[m][5'(c.mem[m].b_start + k)] =
                  source_value(bus[c.mem[m].b_delay + k], c.mem[m].b_sel);
            end
         end
      end
   endtask

   task automatic compare_mems();
      for (int m = 0; m < 2; m++) begin
         for (int a = 0; a < 32; a++) begin
            host_access(1'b0, mem_addr(m, a), 32'd0);
            check_word($sformatf("mem%0d[%0d]", m, a), word[15:0], model_mem[m][a]);
         end
      end
   endtask

   // reads from the low half and writes into the high half
   task automatic base_conf(int len);
      cfg     = '0;
      cfg.len = 6'(len);
      for (int m = 0; m < 2; m++) begin
         cfg.mem[m].a_start = 5'($urandom_range(16 - len, 0));
         cfg.mem[m].b_start = 5'(16 + $urandom_range(16 - len, 0));
      end
      cfg.alu[0].sel_a = dengine_pkg::SRC_MEM0;
      cfg.alu[0].sel_b = dengine_pkg::SRC_MEM1;
      cfg.alu[0].op    = dengine_pkg::alu_op_e'($urandom_range(6, 0));
   endtask

   task automatic run_and_check();
      write_conf(cfg);
      start_run();
      wait_done();
      run_model(cfg);
      compare_mems();
   endtask

   initial begin
      int n;
      int m;
      int a;
      logic [dengine_pkg::DATA_W-1:0] wval;
      host_req = '0;
      void'($urandom(59044));
      n = 0;
      while (clk !== 1'b0) begin
         @(negedge rst);
         n++;
         if (n > 10) begin
            abort_run("reset was never released");
         end
      end

      // idle status then host write and readback
      read_status();
      check_status(done_bit, 1'b1);
      for (m = 0; m < 2; m++) begin
         for (a = 0; a < 32; a++) begin
            wval = $urandom;
            host_access(1'b1, mem_addr(m, a), wval);
            model_mem[m][a] = wval[15:0];
         end
      end
      repeat (24) begin
         m    = $urandom_range(1, 0);
         a    = $urandom_range(31, 0);
         wval = $urandom;
         host_access(1'b1, mem_addr(m, a), wval);
         model_mem[m][a] = wval[15:0];
      end
      for (m = 0; m < 2; m++) begin
         for (a = 0; a < 32; a++) begin
            host_access(1'b0, mem_addr(m, a), 32'd0);
            check_rdata($sformatf("rd_data mem%0d[%0d]", m, a), word,
                        {{16{model_mem[m][a][15]}}, model_mem[m][a]});
         end
      end

      // every opcode through alu0 into mem0
      for (int op = 0; op < 7; op++) begin
         base_conf($urandom_range(12, 1));
         cfg.mem[0].b_sel   = dengine_pkg::SRC_ALU0;
         cfg.mem[0].b_delay = 4'd2;
         cfg.alu[0].op      = dengine_pkg::alu_op_e'(op);
         run_and_check();
      end

      // alu1 chained behind alu0 with the result into mem1
      repeat (3) begin
         base_conf($urandom_range(12, 1));
         cfg.alu[1].sel_a   = dengine_pkg::SRC_ALU0;
         cfg.alu[1].sel_b   = dengine_pkg::SRC_MEM1;
         cfg.alu[1].op      = dengine_pkg::alu_op_e'($urandom_range(6, 0));
         cfg.mem[1].b_sel   = dengine_pkg::SRC_ALU1;
         cfg.mem[1].b_delay = 4'd3;
         run_and_check();
      end

      // mem0 stream copied into mem1 while mem0 port B stays idle
      repeat (2) begin
         base_conf($urandom_range(12, 1));
         cfg.mem[1].b_sel   = dengine_pkg::SRC_MEM0;
         cfg.mem[1].b_delay = 4'd1;
         run_and_check();
      end

      // staging rewritten while a run is in flight
      base_conf(12);
      cfg.mem[0].b_sel   = dengine_pkg::SRC_ALU0;
      cfg.mem[0].b_delay = 4'd2;
      old_cfg = cfg;
      write_conf(cfg);
      start_run();
      cfg.alu[0].op = dengine_pkg::alu_op_e'((int'(old_cfg.alu[0].op) + 1) % 7);
      cfg.len       = 6'($urandom_range(11, 1));
      host_access(1'b1, conf_addr(8),
                  {23'd0, cfg.alu[0].op, cfg.alu[0].sel_b, cfg.alu[0].sel_a});
      host_access(1'b1, conf_addr(10), 32'(cfg.len));
      wait_done();
      run_model(old_cfg);
      compare_mems();
      start_run();
      wait_done();
      run_model(cfg);
      compare_mems();

      // zero iterations leave both memories alone
      base_conf(4);
      cfg.len            = '0;
      cfg.mem[0].b_sel   = dengine_pkg::SRC_ALU0;
      cfg.mem[0].b_delay = 4'd2;
      cfg.mem[1].b_sel   = dengine_pkg::SRC_MEM0;
      cfg.mem[1].b_delay = 4'd1;
      run_and_check();

      $display("Verification passed");
      $finish;
   end

endmodule

/* flist.f */
rtl/dengine_pkg.sv
rtl/dengine_conf.sv
rtl/dengine_mem.sv
rtl/dengine_alu.sv
rtl/dengine_eng.sv
rtl/dengine_top.sv
bench/dengine_clkgen.sv
bench/dengine_tb.sv
